// File: lcd_status_pkg.sv
package lcd_status_pkg;

    localparam int ERR_BITS  = 9;
    localparam int WARN_BITS = 6;
    localparam int LCD_COLS  = 16;

    // Blocking error bit positions in err_mask
    typedef enum logic [3:0] {
        paper_not_installed = 4'd0,
        paper_empty         = 4'd1,
        no_coffee0          = 4'd2,
        no_coffee1          = 4'd3,
        no_creamer          = 4'd4,
        no_chocolate        = 4'd5,
        pressure_error      = 4'd6,
        pressure_high       = 4'd7,
        status_error        = 4'd8
    } err_code_e;

    typedef enum logic [2:0] {
        filter_almost = 3'd0,
        low_pressure  = 3'd1,
        bin0_low      = 3'd2,
        bin1_low      = 3'd3,
        creamer_low   = 3'd4,
        chocolate_low = 3'd5
    } warn_code_e;

    typedef enum logic [3:0] {
        MSG_IDLE           = 4'd0,
        MSG_FILTER_ALMOST  = 4'd1,
        MSG_FILTER_EMPTY   = 4'd2,
        MSG_FILTER_MISSING = 4'd3,
        MSG_BIN0_LOW       = 4'd4,
        MSG_BIN1_LOW       = 4'd5,
        MSG_CREAMER_LOW    = 4'd6,
        MSG_CHOC_LOW       = 4'd7,
        MSG_PRESS_ERROR    = 4'd8,
        MSG_PRESS_HIGH     = 4'd9,
        MSG_PRESS_LOW      = 4'd10,
        MSG_HW_STATUS      = 4'd11,
        MSG_NO_COFFEE0     = 4'd12,
        MSG_NO_COFFEE1     = 4'd13,
        MSG_NO_CHOC        = 4'd14,
        MSG_NO_CREAMER     = 4'd15
    } msg_id_e;

    // Register select level of one LCD write
    typedef enum logic {
        LCD_INSTR = 1'b0,
        LCD_DATA  = 1'b1
    } lcd_op_e;

    typedef logic [7:0] lcd_char_t;

endpackage

// File: lcd_bus_if.sv
`timescale 1ns/1ps

interface lcd_bus_if;
    import lcd_status_pkg::*;

    lcd_op_e   op;
    lcd_char_t data;
    logic      send;
    logic      busy;

    modport requester (
        output op,
        output data,
        output send,
        input  busy
    );

    modport driver (
        input  op,
        input  data,
        input  send,
        output busy
    );

endinterface

// File: fault_scanner.sv
`timescale 1ns/1ps

module fault_scanner #(
    parameter int unsigned TICK_CYCLES = 50_000_000
) (
    input  logic                              CLOCK_50,
    input  logic                              rst,
    input  logic [lcd_status_pkg::ERR_BITS-1:0] err_mask,
    input  logic [1:0]                        paper_level,
    input  logic [1:0]                        w_pressure,
    input  logic                              bin_0_empty,
    input  logic                              bin_1_empty,
    input  logic                              nd_empty,
    input  logic                              ch_empty,
    output lcd_status_pkg::msg_id_e           msg_sel
);
    import lcd_status_pkg::*;

    localparam int unsigned TICK_W = $clog2(TICK_CYCLES + 1);

    localparam msg_id_e err_msg_tbl [ERR_BITS] = '{
        MSG_FILTER_MISSING, MSG_FILTER_EMPTY, MSG_NO_COFFEE0, MSG_NO_COFFEE1,
        MSG_NO_CREAMER, MSG_NO_CHOC, MSG_PRESS_ERROR, MSG_PRESS_HIGH, MSG_HW_STATUS
    };

    localparam msg_id_e warn_msg_tbl [WARN_BITS] = '{
        MSG_FILTER_ALMOST, MSG_PRESS_LOW, MSG_BIN0_LOW,
        MSG_BIN1_LOW, MSG_CREAMER_LOW, MSG_CHOC_LOW
    };

    logic [WARN_BITS-1:0] warn_mask;
    logic [TICK_W-1:0]    tick_cnt;
    logic                 tick;
    err_code_e            cur_err;
    err_code_e            nxt_err;
    warn_code_e           cur_warn;
    warn_code_e           nxt_warn;
    logic                 show;
    logic                 nxt_show;
    msg_id_e              nxt_msg;

    // Next set bit after cur with wrap, or lowest set bit when cur is gone
    function automatic int unsigned pick_next(input logic [15:0] mask,
                                              input int unsigned width,
                                              input int unsigned cur);
        int unsigned start;
        int unsigned idx;
        int unsigned res;
        logic        found;
        start = mask[cur] ? cur + 1 : 0;
        res   = cur;
        found = 1'b0;
        for (int k = 0; k < 16; k++) begin
            idx = start + k;
            if (idx >= width) begin
                idx = idx - width;
            end
            if (k < width && !found && mask[idx]) begin
                res   = idx;
                found = 1'b1;
            end
        end
        return res;
    endfunction

    always_comb begin
        warn_mask                = '0;
        warn_mask[filter_almost] = (paper_level == 2'd2);
        warn_mask[low_pressure]  = (w_pressure == 2'd0);
        warn_mask[bin0_low]      = bin_0_empty;
        warn_mask[bin1_low]      = bin_1_empty;
        warn_mask[creamer_low]   = nd_empty;
        warn_mask[chocolate_low] = ch_empty;
    end

    assign tick = (tick_cnt == TICK_W'(TICK_CYCLES - 1));

    always_comb begin
        nxt_err  = cur_err;
        nxt_warn = cur_warn;
        nxt_show = 1'b0;
        nxt_msg  = MSG_IDLE;
        if (|err_mask) begin
            nxt_err = err_code_e'(pick_next(16'(err_mask), ERR_BITS, cur_err));
            nxt_msg = err_msg_tbl[nxt_err];
        end else if (|warn_mask) begin
            nxt_show = !show;
            // Warning moves on only when it is about to be shown
            if (!show) begin
                nxt_warn = warn_code_e'(pick_next(16'(warn_mask), WARN_BITS, cur_warn));
            end
            nxt_msg = nxt_show ? warn_msg_tbl[nxt_warn] : MSG_IDLE;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            tick_cnt <= '0;
            cur_err  <= paper_not_installed;
            cur_warn <= filter_almost;
            show     <= 1'b0;
            msg_sel  <= MSG_IDLE;
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            if (tick) begin
                cur_err  <= nxt_err;
                cur_warn <= nxt_warn;
                show     <= nxt_show;
                msg_sel  <= nxt_msg;
            end
        end
    end

endmodule

// File: message_rom.sv
`timescale 1ns/1ps

module message_rom (
    input  lcd_status_pkg::msg_id_e   msg_sel,
    input  logic                      line,
    input  logic [3:0]                col,
    output lcd_status_pkg::lcd_char_t ch
);
    import lcd_status_pkg::*;

    // ============================================================
    // Page text with the leftmost character in the top byte
    // ============================================================
    localparam logic [8*LCD_COLS-1:0] page_text [16][2] = '{
        '{"Coffee Machine  ", "Ready           "},
        '{"Paper Filter    ", "Almost Empty    "},
        '{"Paper Filter    ", "Empty           "},
        '{"Paper Filter    ", "Not Installed   "},
        '{"Coffee Bin 0    ", "Almost Empty    "},
        '{"Coffee Bin 1    ", "Almost Empty    "},
        '{"Creamer         ", "Almost Empty    "},
        '{"Chocolate Powder", "Almost Empty    "},
        '{"Water Pressure  ", "Error!          "},
        '{"High Water      ", "Pressure        "},
        '{"Low Water       ", "Pressure        "},
        '{"Hardware Status ", "Error - Service "},
        '{"No Coffee Bin 0 ", "Cannot Execute  "},
        '{"No Coffee Bin 1 ", "Cannot Execute  "},
        '{"No Chocolate    ", "Cannot Execute  "},
        '{"No Creamer      ", "Cannot Execute  "}
    };

    logic [8*LCD_COLS-1:0] line_text;

    assign line_text = page_text[msg_sel][line];
    assign ch        = line_text[8*(LCD_COLS-1-int'(col)) +: 8];

endmodule

// File: lcd_sequencer.sv
`timescale 1ns/1ps

module lcd_sequencer #(
    parameter int unsigned PWRUP_CYCLES      = 750_000,
    parameter int unsigned WAIT_LONG_CYCLES  = 250_000,
    parameter int unsigned WAIT_SHORT_CYCLES = 5_000,
    parameter int unsigned CLEAR_CYCLES      = 75_000
) (
    input  logic                    CLOCK_50,
    input  logic                    rst,
    input  lcd_status_pkg::msg_id_e msg_sel,
    lcd_bus_if.requester            bus
);
    import lcd_status_pkg::*;

    typedef enum logic [2:0] {
        ST_PWRUP,
        ST_INIT_CMD,
        ST_SET_LINE,
        ST_WRITE_CHAR,
        ST_GAP,
        ST_IDLE,
        ST_CLEAR
    } state_e;

    typedef enum logic [2:0] {
        INIT_WAKE1,
        INIT_WAKE2,
        INIT_WAKE3,
        INIT_FUNC,
        INIT_OFF,
        INIT_CLEAR,
        INIT_ENTRY,
        INIT_ON
    } init_step_e;

    // 8-bit bus, two lines, display off, clear, increment, display on
    localparam lcd_char_t init_cmd_tbl [8] = '{
        8'h30, 8'h30, 8'h30, 8'h38, 8'h08, 8'h01, 8'h06, 8'h0C
    };

    state_e     state;
    state_e     ret_state;
    init_step_e init_step;
    logic [31:0] gap_cnt;
    logic [31:0] gap_len;
    logic        line;
    logic [3:0]  col;
    msg_id_e     prev_msg;
    logic        pending;
    lcd_char_t   rom_ch;

    message_rom message_rom_inst (
        .msg_sel (msg_sel),
        .line    (line),
        .col     (col),
        .ch      (rom_ch)
    );

    function automatic logic [31:0] init_gap(input init_step_e step);
        case (step)
            INIT_WAKE1: return WAIT_LONG_CYCLES;
            INIT_CLEAR: return CLEAR_CYCLES;
            default:    return WAIT_SHORT_CYCLES;
        endcase
    endfunction

    // ============================================================
    // Change detection
    // ============================================================
    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            prev_msg <= MSG_IDLE;
            pending  <= 1'b0;
        end else begin
            prev_msg <= msg_sel;
            if (msg_sel != prev_msg) begin
                pending <= 1'b1;
            end else if (state == ST_CLEAR && !bus.busy) begin
                pending <= 1'b0;
            end
        end
    end

    // ============================================================
    // Init and page write FSM
    // ============================================================
    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            state     <= ST_PWRUP;
            ret_state <= ST_IDLE;
            init_step <= INIT_WAKE1;
            gap_cnt   <= '0;
            gap_len   <= '0;
            line      <= 1'b0;
            col       <= '0;
            bus.send  <= 1'b0;
        end else begin
            bus.send <= 1'b0;
            case (state)
                ST_PWRUP: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_cnt >= PWRUP_CYCLES) begin
                        state <= ST_INIT_CMD;
                    end
                end
                ST_INIT_CMD: begin
                    if (!bus.busy) begin
                        bus.op   <= LCD_INSTR;
                        bus.data <= init_cmd_tbl[init_step];
                        bus.send <= 1'b1;
                        gap_cnt  <= '0;
                        gap_len  <= init_gap(init_step);
                        state    <= ST_GAP;
                        if (init_step == INIT_ON) begin
                            line      <= 1'b0;
                            ret_state <= ST_SET_LINE;
                        end else begin
                            init_step <= init_step_e'(init_step + 3'd1);
                            ret_state <= ST_INIT_CMD;
                        end
                    end
                end
                ST_SET_LINE: begin
                    if (!bus.busy) begin
                        bus.op    <= LCD_INSTR;
                        bus.data  <= line ? 8'hC0 : 8'h80;
                        bus.send  <= 1'b1;
                        col       <= '0;
                        gap_cnt   <= '0;
                        gap_len   <= WAIT_SHORT_CYCLES;
                        ret_state <= ST_WRITE_CHAR;
                        state     <= ST_GAP;
                    end
                end
                ST_WRITE_CHAR: begin
                    if (!bus.busy) begin
                        bus.op   <= LCD_DATA;
                        bus.data <= rom_ch;
                        bus.send <= 1'b1;
                        gap_cnt  <= '0;
                        gap_len  <= WAIT_SHORT_CYCLES;
                        state    <= ST_GAP;
                        if (col != 4'(LCD_COLS - 1)) begin
                            col       <= col + 4'd1;
                            ret_state <= ST_WRITE_CHAR;
                        end else if (!line) begin
                            line      <= 1'b1;
                            ret_state <= ST_SET_LINE;
                        end else begin
                            ret_state <= ST_IDLE;
                        end
                    end
                end
                ST_GAP: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (!bus.busy && gap_cnt >= gap_len) begin
                        state <= ret_state;
                    end
                end
                ST_IDLE: begin
                    if (pending) begin
                        state <= ST_CLEAR;
                    end
                end
                ST_CLEAR: begin
                    if (!bus.busy) begin
                        bus.op    <= LCD_INSTR;
                        bus.data  <= 8'h01;
                        bus.send  <= 1'b1;
                        line      <= 1'b0;
                        gap_cnt   <= '0;
                        gap_len   <= CLEAR_CYCLES;
                        ret_state <= ST_SET_LINE;
                        state     <= ST_GAP;
                    end
                end
                default: state <= ST_PWRUP;
            endcase
        end
    end

endmodule

// File: lcd_bus_driver.sv
`timescale 1ns/1ps

module lcd_bus_driver #(
    parameter int unsigned E_PULSE_CYCLES = 25
) (
    input  logic                      CLOCK_50,
    input  logic                      rst,
    lcd_bus_if.driver                 bus,
    output lcd_status_pkg::lcd_char_t lcd_data,
    output logic                      lcd_rs,
    output logic                      lcd_en
);
    import lcd_status_pkg::*;

    localparam int unsigned PULSE_W = $clog2(E_PULSE_CYCLES + 1);

    logic [PULSE_W-1:0] pulse_cnt;

    // Bus value held until the next write
    always_ff @(posedge CLOCK_50) begin
        if (bus.send) begin
            lcd_data <= bus.data;
            lcd_rs   <= (bus.op == LCD_DATA);
        end
    end

    // Enable pulse timing with busy held one cycle past the falling edge
    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            lcd_en    <= 1'b0;
            bus.busy  <= 1'b0;
            pulse_cnt <= '0;
        end else if (bus.send) begin
            lcd_en    <= 1'b1;
            bus.busy  <= 1'b1;
            pulse_cnt <= '0;
        end else if (lcd_en) begin
            if (pulse_cnt == PULSE_W'(E_PULSE_CYCLES - 1)) begin
                lcd_en <= 1'b0;
            end else begin
                pulse_cnt <= pulse_cnt + 1'b1;
            end
        end else if (bus.busy) begin
            bus.busy <= 1'b0;
        end
    end

endmodule

// File: lcd_status_top.sv
`timescale 1ns/1ps

module lcd_status_top #(
    parameter int unsigned TICK_CYCLES       = 50_000_000,
    parameter int unsigned PWRUP_CYCLES      = 750_000,
    parameter int unsigned WAIT_LONG_CYCLES  = 250_000,
    parameter int unsigned WAIT_SHORT_CYCLES = 5_000,
    parameter int unsigned CLEAR_CYCLES      = 75_000,
    parameter int unsigned E_PULSE_CYCLES    = 25
) (
    input  logic                                CLOCK_50,
    input  logic                                rst,
    input  logic [lcd_status_pkg::ERR_BITS-1:0] err_mask,
    input  logic [1:0]                          paper_level,
    input  logic [1:0]                          w_pressure,
    input  logic                                bin_0_empty,
    input  logic                                bin_1_empty,
    input  logic                                nd_empty,
    input  logic                                ch_empty,
    output lcd_status_pkg::lcd_char_t           lcd_data,
    output logic                                lcd_rs,
    output logic                                lcd_en
);
    import lcd_status_pkg::*;

    msg_id_e msg_sel;

    lcd_bus_if lcd_bus ();

    fault_scanner #(
        .TICK_CYCLES (TICK_CYCLES)
    ) fault_scanner_inst (
        .CLOCK_50    (CLOCK_50),
        .rst         (rst),
        .err_mask    (err_mask),
        .paper_level (paper_level),
        .w_pressure  (w_pressure),
        .bin_0_empty (bin_0_empty),
        .bin_1_empty (bin_1_empty),
        .nd_empty    (nd_empty),
        .ch_empty    (ch_empty),
        .msg_sel     (msg_sel)
    );

    lcd_sequencer #(
        .PWRUP_CYCLES      (PWRUP_CYCLES),
        .WAIT_LONG_CYCLES  (WAIT_LONG_CYCLES),
        .WAIT_SHORT_CYCLES (WAIT_SHORT_CYCLES),
        .CLEAR_CYCLES      (CLEAR_CYCLES)
    ) lcd_sequencer_inst (
        .CLOCK_50 (CLOCK_50),
        .rst      (rst),
        .msg_sel  (msg_sel),
        .bus      (lcd_bus.requester)
    );

    lcd_bus_driver #(
        .E_PULSE_CYCLES (E_PULSE_CYCLES)
    ) lcd_bus_driver_inst (
        .CLOCK_50 (CLOCK_50),
        .rst      (rst),
        .bus      (lcd_bus.driver),
        .lcd_data (lcd_data),
        .lcd_rs   (lcd_rs),
        .lcd_en   (lcd_en)
    );

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic CLOCK_50
);

    initial begin
        CLOCK_50 = 1'b0;
        forever #(PERIOD_NS / 2.0) CLOCK_50 = ~CLOCK_50;
    end

endmodule

// File: lcd_status_tb.sv
`timescale 1ns/1ps

module lcd_status_tb;
    import lcd_status_pkg::*;

    localparam int TICK_CYCLES  = 400;
    localparam int PAGE_LIMIT   = 3 * TICK_CYCLES;
    localparam int RUN_LIMIT    = 40 * TICK_CYCLES;

    logic                CLOCK_50;
    logic                rst;
    logic [ERR_BITS-1:0] err_mask;
    logic [1:0]          paper_level;
    logic [1:0]          w_pressure;
    logic                bin_0_empty;
    logic                bin_1_empty;
    logic                nd_empty;
    logic                ch_empty;
    lcd_char_t           lcd_data;
    logic                lcd_rs;
    logic                lcd_en;

    int errors = 0;
    int checks = 0;
    int cycle_cnt = 0;

    // Screen model state
    lcd_char_t screen [2][LCD_COLS];
    lcd_char_t instr_log [$];
    logic      cur_row = 1'b0;
    logic [3:0] cur_col = '0;
    logic      en_prev = 1'b0;
    int        clear_count = 0;
    int        data_count = 0;
    int        data_since_clear = 0;

    tb_clock #(.PERIOD_NS(8)) tb_clock_inst (.CLOCK_50(CLOCK_50));

    lcd_status_top #(
        .TICK_CYCLES       (TICK_CYCLES),
        .PWRUP_CYCLES      (20),
        .WAIT_LONG_CYCLES  (10),
        .WAIT_SHORT_CYCLES (4),
        .CLEAR_CYCLES      (10),
        .E_PULSE_CYCLES    (3)
    ) lcd_status_top_inst (
        .CLOCK_50    (CLOCK_50),
        .rst         (rst),
        .err_mask    (err_mask),
        .paper_level (paper_level),
        .w_pressure  (w_pressure),
        .bin_0_empty (bin_0_empty),
        .bin_1_empty (bin_1_empty),
        .nd_empty    (nd_empty),
        .ch_empty    (ch_empty),
        .lcd_data    (lcd_data),
        .lcd_rs      (lcd_rs),
        .lcd_en      (lcd_en)
    );

    // ============================================================
    // LCD screen model acting on the falling edge of lcd_en
    // ============================================================
    initial begin
        for (int r = 0; r < 2; r++) begin
            for (int c = 0; c < LCD_COLS; c++) begin
                screen[r][c] = 8'h20;
            end
        end
    end

    always @(negedge CLOCK_50) begin
        if (en_prev && !lcd_en) begin
            if (!lcd_rs) begin
                instr_log.push_back(lcd_data);
                if (lcd_data == 8'h01) begin
                    for (int r = 0; r < 2; r++) begin
                        for (int c = 0; c < LCD_COLS; c++) begin
                            screen[r][c] = 8'h20;
                        end
                    end
                    cur_row = 1'b0;
                    cur_col = '0;
                    clear_count++;
                    data_since_clear = 0;
                end else if (lcd_data == 8'h80 || lcd_data == 8'hC0) begin
                    cur_row = lcd_data[6];
                    cur_col = '0;
                end
            end else begin
                screen[cur_row][cur_col] = lcd_data;
                cur_col = cur_col + 4'd1;
                data_count++;
                data_since_clear++;
            end
        end
        en_prev = lcd_en;
    end

    always @(posedge CLOCK_50) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= RUN_LIMIT);
        $display("Timeout: run stopped after %0d cycles", cycle_cnt);
        $display("tests failed");
        $finish;
    end

    // Expected page text without trailing spaces
    function automatic string msg_text(input msg_id_e id, input logic line);
        case (id)
            MSG_IDLE:           return line ? "Ready" : "Coffee Machine";
            MSG_FILTER_ALMOST:  return line ? "Almost Empty" : "Paper Filter";
            MSG_FILTER_EMPTY:   return line ? "Empty" : "Paper Filter";
            MSG_FILTER_MISSING: return line ? "Not Installed" : "Paper Filter";
            MSG_BIN0_LOW:       return line ? "Almost Empty" : "Coffee Bin 0";
            MSG_BIN1_LOW:       return line ? "Almost Empty" : "Coffee Bin 1";
            MSG_CREAMER_LOW:    return line ? "Almost Empty" : "Creamer";
            MSG_CHOC_LOW:       return line ? "Almost Empty" : "Chocolate Powder";
            MSG_PRESS_ERROR:    return line ? "Error!" : "Water Pressure";
            MSG_PRESS_HIGH:     return line ? "Pressure" : "High Water";
            MSG_PRESS_LOW:      return line ? "Pressure" : "Low Water";
            MSG_HW_STATUS:      return line ? "Error - Service" : "Hardware Status";
            MSG_NO_COFFEE0:     return line ? "Cannot Execute" : "No Coffee Bin 0";
            MSG_NO_COFFEE1:     return line ? "Cannot Execute" : "No Coffee Bin 1";
            MSG_NO_CHOC:        return line ? "Cannot Execute" : "No Chocolate";
            default:            return line ? "Cannot Execute" : "No Creamer";
        endcase
    endfunction

    // ============================================================
    // Compare tasks
    // ============================================================
    task automatic check_msg(input msg_id_e exp);
        string     exp_text;
        string     got_text;
        lcd_char_t exp_ch;
        logic      mismatch;
        checks++;
        for (int r = 0; r < 2; r++) begin
            exp_text = msg_text(exp, r[0]);
            got_text = "";
            mismatch = 1'b0;
            for (int c = 0; c < LCD_COLS; c++) begin
                exp_ch = (c < exp_text.len()) ? lcd_char_t'(exp_text[c]) : 8'h20;
                if (screen[r][c] != exp_ch) begin
                    mismatch = 1'b1;
                end
                got_text = {got_text, $sformatf("%c", screen[r][c])};
            end
            if (mismatch) begin
                errors++;
                $display("FAIL %0t: line %0d reads \"%s\", expected \"%s\" of %s",
                         $time, r, got_text, exp_text, exp.name());
            end
        end
    endtask

    task automatic check_byte(input string what, input lcd_char_t got, input lcd_char_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Waits for a clear followed by a complete 32 character page
    task automatic wait_new_page(input int limit);
        int   start_clears;
        int   waited;
        logic done;
        start_clears = clear_count;
        waited = 0;
        done = 1'b0;
        while (!done && waited < limit) begin
            @(posedge CLOCK_50);
            waited++;
            done = (clear_count > start_clears) && (data_since_clear == 2 * LCD_COLS);
        end
        if (!done) begin
            errors++;
            $display("No new page was written within %0d cycles at time %0t", limit, $time);
        end
    endtask

    // ============================================================
    // Directed tests
    // ============================================================
    task automatic init_and_idle_page();
        lcd_char_t exp_init [8];
        exp_init = '{8'h30, 8'h30, 8'h30, 8'h38, 8'h08, 8'h01, 8'h06, 8'h0C};
        check_bit("lcd_en after reset", lcd_en, 1'b0);
        wait_new_page(PAGE_LIMIT);
        check_count("instructions up to first page", instr_log.size(), 10);
        if (instr_log.size() >= 8) begin
            for (int i = 0; i < 8; i++) begin
                check_byte($sformatf("init instruction %0d", i), instr_log[i], exp_init[i]);
            end
        end
        check_count("data writes of first page", data_count, 2 * LCD_COLS);
        check_msg(MSG_IDLE);
    endtask

    task automatic single_error_page();
        @(negedge CLOCK_50);
        err_mask[pressure_high] = 1'b1;
        wait_new_page(2 * TICK_CYCLES);
        check_msg(MSG_PRESS_HIGH);
        @(negedge CLOCK_50);
        err_mask[pressure_high] = 1'b0;
        wait_new_page(PAGE_LIMIT);
        check_msg(MSG_IDLE);
    endtask

    task automatic error_rotation();
        @(negedge CLOCK_50);
        err_mask[no_coffee0]   = 1'b1;
        err_mask[no_creamer]   = 1'b1;
        err_mask[status_error] = 1'b1;
        wait_new_page(PAGE_LIMIT);
        check_msg(MSG_NO_COFFEE0);
        wait_new_page(PAGE_LIMIT);
        check_msg(MSG_NO_CREAMER);
        wait_new_page(PAGE_LIMIT);
        check_msg(MSG_HW_STATUS);
        wait_new_page(PAGE_LIMIT);
        check_msg(MSG_NO_COFFEE0);
    endtask

    task automatic warning_alternation();
        @(negedge CLOCK_50);
        err_mask    = '0;
        w_pressure  = 2'd0;
        bin_0_empty = 1'b1;
        wait_new_page(PAGE_LIMIT);
        check_msg(MSG_PRESS_LOW);
        wait_new_page(PAGE_LIMIT);
        check_msg(MSG_IDLE);
        wait_new_page(PAGE_LIMIT);
        check_msg(MSG_BIN0_LOW);
        wait_new_page(PAGE_LIMIT);
        check_msg(MSG_IDLE);
        wait_new_page(PAGE_LIMIT);
        check_msg(MSG_PRESS_LOW);
        // Error takes over from the warnings
        @(negedge CLOCK_50);
        err_mask[no_chocolate] = 1'b1;
        wait_new_page(PAGE_LIMIT);
        check_msg(MSG_NO_CHOC);
    endtask

    task automatic steady_screen();
        int clears_before;
        int data_before;
        clears_before = clear_count;
        data_before = data_count;
        repeat (3 * TICK_CYCLES) @(posedge CLOCK_50);
        check_count("clear instructions over three ticks", clear_count - clears_before, 0);
        check_count("data writes over three ticks", data_count - data_before, 0);
        check_msg(MSG_NO_CHOC);
    endtask

    initial begin
        rst         = 1'b1;
        err_mask    = '0;
        paper_level = 2'd1;
        w_pressure  = 2'd1;
        bin_0_empty = 1'b0;
        bin_1_empty = 1'b0;
        nd_empty    = 1'b0;
        ch_empty    = 1'b0;
        repeat (5) @(negedge CLOCK_50);
        rst = 1'b0;
        init_and_idle_page();
        single_error_page();
        error_rotation();
        warning_alternation();
        steady_screen();
        $display("Summary: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: src.f
lcd_status_pkg.sv
lcd_bus_if.sv
fault_scanner.sv
message_rom.sv
lcd_sequencer.sv
lcd_bus_driver.sv
lcd_status_top.sv
tb_clock.sv
lcd_status_tb.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of lcd_status_tb

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module lcd_status_tb \
    -f src.f -o lcd_status_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/lcd_status_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "tests failed" sim.log; then
    echo "FAIL, see sim.log"
    exit 1
fi
echo "PASS"
exit 0
